/* filelist.f */
nabp_pkg.sv
nabp_state_control.sv
nabp_shifter.sv
nabp_filter_mapper.sv
nabp_line_accumulator.sv
nabp_top.sv
tb_nabp.sv
+incdir+.

/* nabp_filter_mapper.sv */
`timescale 1ns/1ps

module nabp_filter_mapper
#(
    parameter int FILL_DEPTH = 8
)
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              shift_en,
    input  nabp_pkg::sample_t sample_in,
    output logic              sample_req,
    output nabp_pkg::sample_t head
);
    import nabp_pkg::*;

    // taps[0] newest, last tap oldest
    sample_t taps [FILL_DEPTH];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < FILL_DEPTH; i++)
                taps[i] <= '0;
        end
        else if (shift_en)
        begin
            taps[0] <= sample_in;
            for (int i = 1; i < FILL_DEPTH; i++)
                taps[i] <= taps[i-1];
        end
    end

    // every shift consumes one sample from the stream
    assign sample_req = shift_en;

    // fill always completes before the first pixel reads this
    assign head = taps[FILL_DEPTH-1];

endmodule

/* nabp_line_accumulator.sv */
`timescale 1ns/1ps

module nabp_line_accumulator
#(
    parameter int IMAGE_SIZE = 16
)
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              pixel_step,
    input  logic              first_angle,
    input  logic              last_angle,
    input  nabp_pkg::sample_t head,
    output logic              pixel_valid,
    output logic              readout_done,
    output nabp_pkg::sum_t    pixel_data
);
    import nabp_pkg::*;

    localparam int IDX_W = (IMAGE_SIZE > 2) ? $clog2(IMAGE_SIZE) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(IMAGE_SIZE - 1);

    sum_t             line_mem [IMAGE_SIZE];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             rd_active;
    logic             wr_last;

    assign wr_last = (wr_idx == LAST_IDX);

    // pixel sums, first angle overwrites what the last job left
    always_ff @(posedge clk)
    begin
        if (pixel_step)
        begin
            if (first_angle)
                line_mem[wr_idx] <= sum_t'(head);
            else
                line_mem[wr_idx] <= line_mem[wr_idx] + sum_t'(head);
        end
        if (rd_active)
            pixel_data <= line_mem[rd_idx];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_idx       <= '0;
            rd_idx       <= '0;
            rd_active    <= 1'b0;
            pixel_valid  <= 1'b0;
            readout_done <= 1'b0;
        end
        else
        begin
            pixel_valid  <= 1'b0;
            readout_done <= 1'b0;

            if (pixel_step)
            begin
                wr_idx <= wr_last ? '0 : wr_idx + 1'b1;
                // last pixel of last angle starts the readout
                if (wr_last && last_angle)
                begin
                    rd_active <= 1'b1;
                    rd_idx    <= '0;
                end
            end

            if (rd_active)
            begin
                pixel_valid  <= 1'b1;
                readout_done <= (rd_idx == LAST_IDX);
                if (rd_idx == LAST_IDX)
                    rd_active <= 1'b0;
                else
                    rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    // no angle may still be stepping once the line streams out
    assert property (@(posedge clk) disable iff (!reset_n)
        rd_active |-> !pixel_step);

endmodule

/* nabp_pkg.sv */
package nabp_pkg;

    // filtered projection sample
    typedef logic [11:0] sample_t;

    // one pixel of the summed line
    typedef logic [19:0] sum_t;

    // unsigned fixed point, integer part on top
    typedef logic [15:0] accu_t;

    localparam int ACCU_FRAC_BITS = 12;
    localparam int ACCU_INT_BITS  = $bits(accu_t) - ACCU_FRAC_BITS;

    typedef enum logic [1:0] {
        ready_s,
        fill_s,
        fill_done_s,
        shift_s
    } shifter_state_t;

    // job sequencer, prefixed since the shifter owns fill_s and shift_s
    typedef enum logic [1:0] {
        seq_idle_s,
        seq_fill_s,
        seq_shift_s,
        seq_readout_s
    } seq_state_t;

endpackage

/* nabp_shifter.sv */
`timescale 1ns/1ps

module nabp_shifter
#(
    parameter int IMAGE_SIZE = 16,
    parameter int FILL_DEPTH = 8
)
(
    input  logic            clk,
    input  logic            reset_n,
    input  logic            fill_kick,
    input  logic            shift_kick,
    input  nabp_pkg::accu_t accu_base,
    output logic            fill_done,
    output logic            shift_done,
    output logic            shift_en,
    output logic            pixel_step
);
    import nabp_pkg::*;

    localparam int FILL_W  = $clog2(FILL_DEPTH + 1);
    localparam int SHIFT_W = (IMAGE_SIZE > 2) ? $clog2(IMAGE_SIZE) : 1;
    localparam logic [FILL_W-1:0]  FILL_INIT  = FILL_W'(FILL_DEPTH);
    localparam logic [SHIFT_W-1:0] SHIFT_INIT = SHIFT_W'(IMAGE_SIZE - 1);

    shifter_state_t     state;
    shifter_state_t     next_state;
    logic [FILL_W-1:0]  fill_cnt;
    logic [SHIFT_W-1:0] shift_cnt;
    accu_t              accu;
    accu_t              accu_prev;
    logic               step_shift;

    // a shift is due when the integer part moves on
    assign step_shift = accu[ACCU_FRAC_BITS +: ACCU_INT_BITS] !=
                        accu_prev[ACCU_FRAC_BITS +: ACCU_INT_BITS];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_cnt   <= FILL_INIT;
            shift_cnt  <= SHIFT_INIT;
            shift_en   <= 1'b0;
            pixel_step <= 1'b0;
        end
        else
        begin
            shift_en   <= 1'b0;
            pixel_step <= 1'b0;

            if (state == fill_s && fill_cnt != '0)
            begin
                fill_cnt <= fill_cnt - 1'b1;
                shift_en <= 1'b1;
            end
            else
                fill_cnt <= FILL_INIT;

            if (state == shift_s && shift_cnt != '0)
            begin
                shift_cnt  <= shift_cnt - 1'b1;
                pixel_step <= 1'b1;
                shift_en   <= step_shift;
            end
            else
                shift_cnt <= SHIFT_INIT;

            // step 0 goes out on the kick, it never shifts
            if (state == fill_done_s && shift_kick)
                pixel_step <= 1'b1;
        end
    end

    // wraps freely, only integer boundary crossings matter
    always_ff @(posedge clk)
    begin
        if (state == shift_s)
        begin
            accu_prev <= accu;
            accu      <= accu + accu_base;
        end
        else
        begin
            accu_prev <= '0;
            accu      <= accu_base;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= ready_s;
        else
            state <= next_state;
    end

    // mealy outputs
    assign fill_done  = (state == fill_s) && (fill_cnt == '0);
    assign shift_done = (state == shift_s) && (shift_cnt == '0);

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (fill_kick)
                    next_state = fill_s;
            fill_s:
                if (fill_done)
                    next_state = fill_done_s;
            fill_done_s:
                if (shift_kick)
                    next_state = shift_s;
            shift_s:
                if (shift_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // registered shifts must land inside their own phase
    assert property (@(posedge clk) disable iff (!reset_n)
        (state == ready_s || state == fill_done_s) |-> !shift_en);

endmodule

/* nabp_state_control.sv */
`timescale 1ns/1ps

module nabp_state_control
#(
    parameter int NUM_ANGLES = 4
)
(
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    input  logic fill_done,
    input  logic shift_done,
    input  logic readout_done,
    output logic fill_kick,
    output logic shift_kick,
    output logic first_angle,
    output logic last_angle,
    output logic busy,
    output logic done
);
    import nabp_pkg::*;

    localparam int ANGLE_W = (NUM_ANGLES > 1) ? $clog2(NUM_ANGLES) : 1;
    localparam logic [ANGLE_W-1:0] LAST_ANGLE = ANGLE_W'(NUM_ANGLES - 1);

    seq_state_t state;
    logic [ANGLE_W-1:0] angle_cnt;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state      <= seq_idle_s;
            angle_cnt  <= '0;
            fill_kick  <= 1'b0;
            shift_kick <= 1'b0;
            done       <= 1'b0;
        end
        else
        begin
            // kicks and done are single cycle pulses
            fill_kick  <= 1'b0;
            shift_kick <= 1'b0;
            done       <= 1'b0;

            case (state)
                seq_idle_s:
                    if (start)
                    begin
                        angle_cnt <= '0;
                        fill_kick <= 1'b1;
                        state     <= seq_fill_s;
                    end
                seq_fill_s:
                    if (fill_done)
                    begin
                        shift_kick <= 1'b1;
                        state      <= seq_shift_s;
                    end
                seq_shift_s:
                    if (shift_done)
                    begin
                        if (last_angle)
                            state <= seq_readout_s;
                        else
                        begin
                            // next angle reuses the same base
                            angle_cnt <= angle_cnt + 1'b1;
                            fill_kick <= 1'b1;
                            state     <= seq_fill_s;
                        end
                    end
                seq_readout_s:
                    if (readout_done)
                    begin
                        done  <= 1'b1;
                        state <= seq_idle_s;
                    end
                default:
                    state <= seq_idle_s;
            endcase
        end
    end

    assign first_angle = (angle_cnt == '0);
    assign last_angle  = (angle_cnt == LAST_ANGLE);
    assign busy        = (state != seq_idle_s);

    // the shifter accepts one kick at a time
    assert property (@(posedge clk) disable iff (!reset_n)
        !(fill_kick && shift_kick));

endmodule

/* nabp_top.sv */
`timescale 1ns/1ps

module nabp_top
#(
    parameter int IMAGE_SIZE = 16,
    parameter int FILL_DEPTH = 8,
    parameter int NUM_ANGLES = 4
)
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start,
    input  nabp_pkg::accu_t   accu_base,
    input  nabp_pkg::sample_t sample_in,
    output logic              sample_req,
    output logic              busy,
    output logic              pixel_valid,
    output nabp_pkg::sum_t    pixel_data,
    output logic              done
);
    import nabp_pkg::*;

    logic    fill_kick;
    logic    shift_kick;
    logic    fill_done;
    logic    shift_done;
    logic    shift_en;
    logic    pixel_step;
    logic    first_angle;
    logic    last_angle;
    logic    readout_done;
    sample_t head;

    nabp_state_control #(
        .NUM_ANGLES (NUM_ANGLES)
    ) u_state_control (
        .clk          (clk),
        .reset_n      (reset_n),
        .start        (start),
        .fill_done    (fill_done),
        .shift_done   (shift_done),
        .readout_done (readout_done),
        .fill_kick    (fill_kick),
        .shift_kick   (shift_kick),
        .first_angle  (first_angle),
        .last_angle   (last_angle),
        .busy         (busy),
        .done         (done)
    );

    nabp_shifter #(
        .IMAGE_SIZE (IMAGE_SIZE),
        .FILL_DEPTH (FILL_DEPTH)
    ) u_shifter (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_kick  (fill_kick),
        .shift_kick (shift_kick),
        .accu_base  (accu_base),
        .fill_done  (fill_done),
        .shift_done (shift_done),
        .shift_en   (shift_en),
        .pixel_step (pixel_step)
    );

    nabp_filter_mapper #(
        .FILL_DEPTH (FILL_DEPTH)
    ) u_filter_mapper (
        .clk        (clk),
        .reset_n    (reset_n),
        .shift_en   (shift_en),
        .sample_in  (sample_in),
        .sample_req (sample_req),
        .head       (head)
    );

    nabp_line_accumulator #(
        .IMAGE_SIZE (IMAGE_SIZE)
    ) u_line_accumulator (
        .clk          (clk),
        .reset_n      (reset_n),
        .pixel_step   (pixel_step),
        .first_angle  (first_angle),
        .last_angle   (last_angle),
        .head         (head),
        .pixel_valid  (pixel_valid),
        .readout_done (readout_done),
        .pixel_data   (pixel_data)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the nabp testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_nabp -f filelist.f

./obj_dir/Vtb_nabp > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
# a run that stopped early prints neither message
if ! grep -q "Test completed successfully" sim.log; then
    exit 1
fi
exit 0

/* tb_nabp_model.svh */
// galois lfsr, taps x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// one lfsr step per sample bit, msb first
function automatic sample_t next_sample();
    sample_t value;
    value = '0;
    for (int i = 0; i < $bits(sample_t); i++)
    begin
        value = {value[$bits(sample_t)-2:0], lfsr[0]};
        lfsr = lfsr_step(lfsr);
    end
    return value;
endfunction

// fill samples plus one per integer crossing of k * base
function automatic int samples_per_angle(input accu_t base);
    return FILL_DEPTH + (((IMAGE_SIZE - 1) * int'(base)) >> ACCU_FRAC_BITS);
endfunction

// sample number at the buffer head when pixel k is summed
function automatic int head_offset(input int k, input accu_t base);
    if (k == 0)
        return 0;
    return ((k - 1) * int'(base)) >> ACCU_FRAC_BITS;
endfunction

function automatic int expected_pixel(input int k, input accu_t base);
    int total;
    int per;
    total = 0;
    per = samples_per_angle(base);
    for (int a = 0; a < NUM_ANGLES; a++)
        total += int'(job_samples[a * per + head_offset(k, base)]);
    return total;
endfunction

// base zero never shifts, so each angle only contributes its first sample
function automatic int first_sample_sum(input accu_t base);
    int total;
    total = 0;
    for (int a = 0; a < NUM_ANGLES; a++)
        total += int'(job_samples[a * samples_per_angle(base)]);
    return total;
endfunction

/* tb_nabp.sv */
`timescale 1ns/1ps

module tb_nabp;
    import nabp_pkg::*;

    localparam int IMAGE_SIZE   = 16;
    localparam int FILL_DEPTH   = 8;
    localparam int NUM_ANGLES   = 4;
    localparam int NUM_JOBS     = 5;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_SAMPLES  = NUM_ANGLES * (FILL_DEPTH + IMAGE_SIZE);
    localparam int TIMEOUT      = RESET_CYCLES + 10 + NUM_JOBS *
        (NUM_ANGLES * (FILL_DEPTH + IMAGE_SIZE + 8) + IMAGE_SIZE + 20);

    logic        clk;
    logic        reset_n;
    logic        start;
    accu_t       accu_base;
    sample_t     sample_in;
    logic        sample_req;
    logic        busy;
    logic        pixel_valid;
    logic        done;
    sum_t        pixel_data;

    sample_t     job_samples [MAX_SAMPLES];
    logic [15:0] lfsr;
    string       test_name;
    int          sample_cnt   = 0;
    int          pixel_cnt    = 0;
    int          done_cnt     = 0;
    int          cycle_cnt    = 0;
    int          mismatch_cnt = 0;
    int          protocol_cnt = 0;

    `include "tb_nabp_model.svh"

    nabp_top #(
        .IMAGE_SIZE (IMAGE_SIZE),
        .FILL_DEPTH (FILL_DEPTH),
        .NUM_ANGLES (NUM_ANGLES)
    ) DUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .accu_base   (accu_base),
        .sample_in   (sample_in),
        .sample_req  (sample_req),
        .busy        (busy),
        .pixel_valid (pixel_valid),
        .pixel_data  (pixel_data),
        .done        (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT)
        begin
            $display("timeout, the jobs did not finish within %0d cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    end

    // sample stream, the DUT takes sample_in on the edge after a request
    initial
    begin
        lfsr = 16'd28;
        sample_in = next_sample();
        forever
        begin
            @(negedge clk);
            if (sample_req)
            begin
                @(posedge clk);
                #1;
                if (sample_cnt < MAX_SAMPLES)
                    job_samples[sample_cnt] = sample_in;
                sample_cnt++;
                sample_in = next_sample();
            end
        end
    end

    // readout monitor
    always @(negedge clk)
    begin
        if (pixel_valid)
        begin
            assert (pixel_cnt < IMAGE_SIZE)
            else
            begin
                protocol_cnt++;
                $display("%s: readout gave more pixels than the line holds", test_name);
            end
            if (pixel_cnt < IMAGE_SIZE)
            begin
                assert (pixel_data == sum_t'(expected_pixel(pixel_cnt, accu_base)))
                else
                begin
                    mismatch_cnt++;
                    $display("mismatch %s pixel %0d: expected %0d, actual %0d", test_name,
                             pixel_cnt, expected_pixel(pixel_cnt, accu_base), pixel_data);
                end
                if (accu_base == '0)
                    assert (pixel_data == sum_t'(first_sample_sum(accu_base)))
                    else
                    begin
                        mismatch_cnt++;
                        $display("mismatch %s first sample sum: expected %0d, actual %0d",
                                 test_name, first_sample_sum(accu_base), pixel_data);
                    end
            end
            pixel_cnt++;
        end
        if (done)
        begin
            assert (pixel_cnt == IMAGE_SIZE)
            else
            begin
                mismatch_cnt++;
                $display("mismatch %s readout pixels: expected %0d, actual %0d", test_name,
                         IMAGE_SIZE, pixel_cnt);
            end
            done_cnt++;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        done |-> ($past(pixel_valid) && !pixel_valid))
    else
    begin
        protocol_cnt++;
        $display("done did not come right after the last readout pixel");
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        (sample_req || pixel_valid) |-> busy)
    else
    begin
        protocol_cnt++;
        $display("sample request or readout pixel seen while not busy");
    end

    task automatic pulse_start();
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic run_job(input string name, input accu_t base, input bit extra_start);
        int exp_samples;
        exp_samples = NUM_ANGLES * samples_per_angle(base);
        @(posedge clk);
        #1;
        test_name  = name;
        accu_base  = base;
        sample_cnt = 0;
        pixel_cnt  = 0;
        done_cnt   = 0;
        pulse_start();
        if (extra_start)
        begin
            // a second start in the middle of the angles must be ignored
            repeat (40) @(posedge clk);
            #1;
            assert (busy)
            else
            begin
                protocol_cnt++;
                $display("%s: job was no longer busy at the second start", name);
            end
            pulse_start();
        end
        do
            @(negedge clk);
        while (!done);
        repeat (3) @(negedge clk);
        assert (done_cnt == 1)
        else
        begin
            mismatch_cnt++;
            $display("mismatch %s done pulses: expected 1, actual %0d", name, done_cnt);
        end
        assert (sample_cnt == exp_samples)
        else
        begin
            mismatch_cnt++;
            $display("mismatch %s samples: expected %0d, actual %0d", name, exp_samples,
                     sample_cnt);
        end
    endtask

    initial
    begin
        reset_n   = 1'b0;
        start     = 1'b0;
        accu_base = '0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;
        repeat (3)
        begin
            @(negedge clk);
            assert (!sample_req && !pixel_valid && !done && !busy)
            else
            begin
                protocol_cnt++;
                $display("outputs not idle after reset");
            end
        end

        run_job("base_zero", 16'h0000, 1'b0);
        run_job("base_quarter", 16'h0400, 1'b0);
        run_job("base_0p7", 16'h0B33, 1'b0);
        run_job("base_0p999", 16'h0FFC, 1'b0);
        run_job("start_while_busy", 16'h0B33, 1'b1);

        $display("errors: %0d mismatches, %0d protocol", mismatch_cnt, protocol_cnt);
        if (mismatch_cnt == 0 && protocol_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
